/* src/cpuCore.sv */
// Pipelined core top level with stage wiring and writeback trace port
`default_nettype none

module cpuCore #(
	parameter logic [cpuPkg::XLEN-1:0] ResetPc = '0,
	parameter int DataAddrWidth = 16
) (
	input  wire logic                            clk,
	input  wire logic                            rstN,
	input  wire logic [cpuPkg::XLEN-1:0]         instr,
	input  wire logic                            memAck,
	input  wire logic [cpuPkg::XLEN-1:0]         memRdata,
	output logic      [cpuPkg::XLEN-1:0]         instrAddr,
	output logic                                 memReq,
	output logic                                 memWe,
	output logic      [DataAddrWidth-1:0]        memAddr,
	output logic      [cpuPkg::XLEN-1:0]         memWdata,
	output logic                                 wbEn,
	output logic      [cpuPkg::RegAddrWidth-1:0] wbAddr,
	output logic      [cpuPkg::XLEN-1:0]         wbData,
	output logic                                 halt
);
	import cpuPkg::*;

	logic [XLEN-1:0] fetchedInstr;
	logic stallFront, stallAll, bubble, memBusy;
	fwdSelT fwdA, fwdB;

	logic [RegAddrWidth-1:0] rsAddr, rtAddr;
	logic [XLEN-1:0] exOpA, exOpB, exImm;
	aluOpT exAluOp;
	logic exUseImm, exLoad, exStore, exWrEn, exHalt;
	logic [RegAddrWidth-1:0] exRd;

	logic [XLEN-1:0] memResult, memStoreData;
	logic memLoad, memStore, memWrEn, memHalt;
	logic [RegAddrWidth-1:0] memRd;

	logic wbWrEn, wbHalt;
	logic [RegAddrWidth-1:0] wbRd;

	// Register zero writes never retire to the trace
	assign wbEn = wbWrEn & (wbRd != '0);
	assign wbAddr = wbRd;

	fetchStage #(.ResetPc(ResetPc)) fetch (
		.clk(clk), .rstN(rstN), .instr(instr), .stallFront(stallFront),
		.stallAll(stallAll), .halt(halt), .instrAddr(instrAddr), .fetchedInstr(fetchedInstr)
	);

	decodeStage decode (
		.clk(clk), .rstN(rstN), .fetchedInstr(fetchedInstr), .stallFront(stallFront),
		.stallAll(stallAll), .bubble(bubble), .wrEn(wbEn), .wrAddr(wbRd), .wrData(wbData),
		.rsAddr(rsAddr), .rtAddr(rtAddr), .exOpA(exOpA), .exOpB(exOpB), .exImm(exImm),
		.exAluOp(exAluOp), .exUseImm(exUseImm), .exLoad(exLoad), .exStore(exStore),
		.exWrEn(exWrEn), .exRd(exRd), .exHalt(exHalt)
	);

	executeStage execute (
		.clk(clk), .rstN(rstN), .stallAll(stallAll), .fwdA(fwdA), .fwdB(fwdB),
		.exOpA(exOpA), .exOpB(exOpB), .exImm(exImm), .exAluOp(exAluOp),
		.exUseImm(exUseImm), .exLoad(exLoad), .exStore(exStore), .exWrEn(exWrEn),
		.exRd(exRd), .exHalt(exHalt), .memFwdData(memResult), .wbFwdData(wbData),
		.memResult(memResult), .memStoreData(memStoreData), .memLoad(memLoad),
		.memStore(memStore), .memWrEn(memWrEn), .memRd(memRd), .memHalt(memHalt)
	);

	memoryStage #(.DataAddrWidth(DataAddrWidth)) memory (
		.clk(clk), .rstN(rstN), .memResult(memResult), .memStoreData(memStoreData),
		.memLoad(memLoad), .memStore(memStore), .memWrEn(memWrEn), .memRd(memRd),
		.memHalt(memHalt), .memAck(memAck), .memRdata(memRdata), .memReq(memReq),
		.memWe(memWe), .memAddr(memAddr), .memWdata(memWdata), .memBusy(memBusy),
		.wbWrEn(wbWrEn), .wbRd(wbRd), .wbData(wbData), .wbHalt(wbHalt)
	);

	pipelineControl control (
		.clk(clk), .rstN(rstN), .rsAddr(rsAddr), .rtAddr(rtAddr), .exRd(exRd),
		.exWrEn(exWrEn), .exLoad(exLoad), .memRd(memRd), .memWrEn(memWrEn),
		.memBusy(memBusy), .wbRd(wbRd), .wbWrEn(wbWrEn), .wbHalt(wbHalt),
		.stallFront(stallFront), .bubble(bubble), .stallAll(stallAll),
		.fwdA(fwdA), .fwdB(fwdB), .halt(halt)
	);

endmodule

`default_nettype wire

/* src/cpuPkg.sv */
// ISA field positions, opcode and ALU operation types, forwarding selects
`default_nettype none

package cpuPkg;

	parameter int XLEN = 32;
	parameter int RegAddrWidth = 5;

	// Instruction word fields
	parameter int OpMsb = 31;
	parameter int OpLsb = 26;
	parameter int RdLsb = 21;
	parameter int RsLsb = 16;
	parameter int RtLsb = 11;

	// All-zero word decodes as NOP
	parameter logic [XLEN-1:0] NopInstr = '0;

	typedef enum logic [5:0] {
		OpNop  = 6'd0,
		OpAdd  = 6'd1,
		OpSub  = 6'd2,
		OpAnd  = 6'd3,
		OpOr   = 6'd4,
		OpXor  = 6'd5,
		OpSlt  = 6'd6,
		OpAddi = 6'd7,
		OpLw   = 6'd8,
		OpSw   = 6'd9,
		OpHalt = 6'd10
	} opcodeT;

	typedef enum logic [2:0] {
		AluAdd   = 3'd0,
		AluSub   = 3'd1,
		AluAnd   = 3'd2,
		AluOr    = 3'd3,
		AluXor   = 3'd4,
		AluSlt   = 3'd5,
		AluPassB = 3'd6
	} aluOpT;

	typedef enum logic [1:0] {
		FwdReg = 2'd0,
		FwdMem = 2'd1,
		FwdWb  = 2'd2
	} fwdSelT;

endpackage

`default_nettype wire

/* src/decodeStage.sv */
// Instruction decoder, register file and decode-to-execute register
`default_nettype none

module decodeStage (
	input  wire logic                            clk,
	input  wire logic                            rstN,
	input  wire logic [cpuPkg::XLEN-1:0]         fetchedInstr,
	input  wire logic                            stallFront,
	input  wire logic                            stallAll,
	input  wire logic                            bubble,
	input  wire logic                            wrEn,
	input  wire logic [cpuPkg::RegAddrWidth-1:0] wrAddr,
	input  wire logic [cpuPkg::XLEN-1:0]         wrData,
	output logic      [cpuPkg::RegAddrWidth-1:0] rsAddr,
	output logic      [cpuPkg::RegAddrWidth-1:0] rtAddr,
	output logic      [cpuPkg::XLEN-1:0]         exOpA,
	output logic      [cpuPkg::XLEN-1:0]         exOpB,
	output logic      [cpuPkg::XLEN-1:0]         exImm,
	output cpuPkg::aluOpT                        exAluOp,
	output logic                                 exUseImm,
	output logic                                 exLoad,
	output logic                                 exStore,
	output logic                                 exWrEn,
	output logic      [cpuPkg::RegAddrWidth-1:0] exRd,
	output logic                                 exHalt
);
	import cpuPkg::*;

	opcodeT opcode;
	aluOpT aluOp;
	logic [XLEN-1:0] rsData, rtData, imm;
	logic useImm, isLoad, isStore, writes, isHalt;

	assign opcode = opcodeT'(fetchedInstr[OpMsb:OpLsb]);
	assign imm = {{(XLEN-16){fetchedInstr[15]}}, fetchedInstr[15:0]};
	assign rsAddr = fetchedInstr[RsLsb +: RegAddrWidth];

	always_comb begin
		aluOp = AluPassB;
		useImm = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		writes = 1'b0;
		isHalt = 1'b0;
		rtAddr = fetchedInstr[RtLsb +: RegAddrWidth];
		case (opcode)
			OpAdd: begin aluOp = AluAdd; writes = 1'b1; end
			OpSub: begin aluOp = AluSub; writes = 1'b1; end
			OpAnd: begin aluOp = AluAnd; writes = 1'b1; end
			OpOr:  begin aluOp = AluOr;  writes = 1'b1; end
			OpXor: begin aluOp = AluXor; writes = 1'b1; end
			OpSlt: begin aluOp = AluSlt; writes = 1'b1; end
			OpAddi, OpLw: begin
				aluOp = AluAdd;
				useImm = 1'b1;
				writes = 1'b1;
				isLoad = (opcode == OpLw);
				rtAddr = '0;
			end
			// Store data comes from the rd field
			OpSw: begin
				aluOp = AluAdd;
				useImm = 1'b1;
				isStore = 1'b1;
				rtAddr = fetchedInstr[RdLsb +: RegAddrWidth];
			end
			OpHalt: begin isHalt = 1'b1; rtAddr = '0; end
			default: rtAddr = '0;
		endcase
	end

	regFile regs (
		.clk(clk), .rstN(rstN), .rsAddr(rsAddr), .rtAddr(rtAddr),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData), .rsData(rsData), .rtData(rtData)
	);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			{exLoad, exStore, exWrEn, exHalt} <= '0;
		end else if (!stallAll) begin
			if (bubble || stallFront) begin
				{exLoad, exStore, exWrEn, exHalt} <= '0;
			end else begin
				{exLoad, exStore, exWrEn, exHalt} <= {isLoad, isStore, writes, isHalt};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stallAll) begin
			exOpA <= rsData;
			exOpB <= rtData;
			exImm <= imm;
			exAluOp <= aluOp;
			exUseImm <= useImm;
			exRd <= fetchedInstr[RdLsb +: RegAddrWidth];
		end
	end

endmodule

`default_nettype wire

/* src/executeStage.sv */
// Operand forwarding muxes, ALU and execute-to-memory register
`default_nettype none

module executeStage (
	input  wire logic                            clk,
	input  wire logic                            rstN,
	input  wire logic                            stallAll,
	input  wire cpuPkg::fwdSelT                  fwdA,
	input  wire cpuPkg::fwdSelT                  fwdB,
	input  wire logic [cpuPkg::XLEN-1:0]         exOpA,
	input  wire logic [cpuPkg::XLEN-1:0]         exOpB,
	input  wire logic [cpuPkg::XLEN-1:0]         exImm,
	input  wire cpuPkg::aluOpT                   exAluOp,
	input  wire logic                            exUseImm,
	input  wire logic                            exLoad,
	input  wire logic                            exStore,
	input  wire logic                            exWrEn,
	input  wire logic [cpuPkg::RegAddrWidth-1:0] exRd,
	input  wire logic                            exHalt,
	input  wire logic [cpuPkg::XLEN-1:0]         memFwdData,
	input  wire logic [cpuPkg::XLEN-1:0]         wbFwdData,
	output logic      [cpuPkg::XLEN-1:0]         memResult,
	output logic      [cpuPkg::XLEN-1:0]         memStoreData,
	output logic                                 memLoad,
	output logic                                 memStore,
	output logic                                 memWrEn,
	output logic      [cpuPkg::RegAddrWidth-1:0] memRd,
	output logic                                 memHalt
);
	import cpuPkg::*;

	logic [XLEN-1:0] liveA, liveB, opA, opB, aluB, result;
	logic [XLEN-1:0] holdA, holdB;
	logic holdValid;

	assign liveA = (fwdA == FwdMem) ? memFwdData : (fwdA == FwdWb) ? wbFwdData : exOpA;
	assign liveB = (fwdB == FwdMem) ? memFwdData : (fwdB == FwdWb) ? wbFwdData : exOpB;

	// The writeback producer leaves during a memory stall, so keep the operands
	assign opA = holdValid ? holdA : liveA;
	assign opB = holdValid ? holdB : liveB;
	assign aluB = exUseImm ? exImm : opB;

	always_comb begin
		case (exAluOp)
			AluAdd: result = opA + aluB;
			AluSub: result = opA - aluB;
			AluAnd: result = opA & aluB;
			AluOr:  result = opA | aluB;
			AluXor: result = opA ^ aluB;
			AluSlt: result = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(aluB)};
			default: result = aluB;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			holdValid <= 1'b0;
		end else begin
			holdValid <= stallAll;
		end
	end

	always_ff @(posedge clk) begin
		if (stallAll && !holdValid) begin
			holdA <= liveA;
			holdB <= liveB;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			{memLoad, memStore, memWrEn, memHalt} <= '0;
		end else if (!stallAll) begin
			{memLoad, memStore, memWrEn, memHalt} <= {exLoad, exStore, exWrEn, exHalt};
		end
	end

	always_ff @(posedge clk) begin
		if (!stallAll) begin
			memResult <= result;
			memStoreData <= opB;
			memRd <= exRd;
		end
	end

endmodule

`default_nettype wire

/* src/fetchStage.sv */
// Program counter and fetch-to-decode instruction register
`default_nettype none

module fetchStage #(
	parameter logic [cpuPkg::XLEN-1:0] ResetPc = '0
) (
	input  wire logic                    clk,
	input  wire logic                    rstN,
	input  wire logic [cpuPkg::XLEN-1:0] instr,
	input  wire logic                    stallFront,
	input  wire logic                    stallAll,
	input  wire logic                    halt,
	output logic      [cpuPkg::XLEN-1:0] instrAddr,
	output logic      [cpuPkg::XLEN-1:0] fetchedInstr
);
	import cpuPkg::*;

	logic [XLEN-1:0] pc;
	logic haltSeen;
	logic freeze;

	assign freeze = stallFront | stallAll | halt;
	assign instrAddr = pc;

	// Once a HALT is fetched only NOPs follow it down the pipe
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= ResetPc;
			fetchedInstr <= NopInstr;
			haltSeen <= 1'b0;
		end else if (!freeze) begin
			if (haltSeen) begin
				fetchedInstr <= NopInstr;
			end else begin
				pc <= pc + 1'b1;
				fetchedInstr <= instr;
				haltSeen <= (opcodeT'(instr[OpMsb:OpLsb]) == OpHalt);
			end
		end
	end

endmodule

`default_nettype wire

/* src/memoryStage.sv */
// Four-phase data-memory requester and memory-to-writeback register
`default_nettype none

module memoryStage #(
	parameter int DataAddrWidth = 16
) (
	input  wire logic                            clk,
	input  wire logic                            rstN,
	input  wire logic [cpuPkg::XLEN-1:0]         memResult,
	input  wire logic [cpuPkg::XLEN-1:0]         memStoreData,
	input  wire logic                            memLoad,
	input  wire logic                            memStore,
	input  wire logic                            memWrEn,
	input  wire logic [cpuPkg::RegAddrWidth-1:0] memRd,
	input  wire logic                            memHalt,
	input  wire logic                            memAck,
	input  wire logic [cpuPkg::XLEN-1:0]         memRdata,
	output logic                                 memReq,
	output logic                                 memWe,
	output logic      [DataAddrWidth-1:0]        memAddr,
	output logic      [cpuPkg::XLEN-1:0]         memWdata,
	output logic                                 memBusy,
	output logic                                 wbWrEn,
	output logic      [cpuPkg::RegAddrWidth-1:0] wbRd,
	output logic      [cpuPkg::XLEN-1:0]         wbData,
	output logic                                 wbHalt
);
	import cpuPkg::*;

	typedef enum logic [1:0] {
		StIdle,
		StReq,
		StRelease
	} stateT;

	stateT state, stateNext;
	logic [XLEN-1:0] loadData;
	logic access;

	assign access = memLoad | memStore;
	assign memReq = (state == StReq);
	assign memWe = memStore;
	assign memAddr = memResult[DataAddrWidth-1:0];
	assign memWdata = memStoreData;

	// Busy until ack is seen low after the request drops
	always_comb begin
		stateNext = state;
		memBusy = 1'b0;
		case (state)
			StIdle: begin
				memBusy = access;
				if (access) stateNext = StReq;
			end
			StReq: begin
				memBusy = 1'b1;
				if (memAck) stateNext = StRelease;
			end
			StRelease: begin
				memBusy = memAck;
				if (!memAck) stateNext = StIdle;
			end
			default: stateNext = StIdle;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= StIdle;
		end else begin
			state <= stateNext;
		end
	end

	always_ff @(posedge clk) begin
		if (state == StReq && memAck) begin
			loadData <= memRdata;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbWrEn <= 1'b0;
			wbHalt <= 1'b0;
		end else begin
			wbWrEn <= memWrEn & ~memBusy;
			wbHalt <= memHalt & ~memBusy;
		end
	end

	always_ff @(posedge clk) begin
		wbRd <= memRd;
		wbData <= memLoad ? loadData : memResult;
	end

endmodule

`default_nettype wire

/* src/pipelineControl.sv */
// Hazard detection, forwarding selection, stall generation and halt state
`default_nettype none

module pipelineControl (
	input  wire logic                            clk,
	input  wire logic                            rstN,
	input  wire logic [cpuPkg::RegAddrWidth-1:0] rsAddr,
	input  wire logic [cpuPkg::RegAddrWidth-1:0] rtAddr,
	input  wire logic [cpuPkg::RegAddrWidth-1:0] exRd,
	input  wire logic                            exWrEn,
	input  wire logic                            exLoad,
	input  wire logic [cpuPkg::RegAddrWidth-1:0] memRd,
	input  wire logic                            memWrEn,
	input  wire logic                            memBusy,
	input  wire logic [cpuPkg::RegAddrWidth-1:0] wbRd,
	input  wire logic                            wbWrEn,
	input  wire logic                            wbHalt,
	output logic                                 stallFront,
	output logic                                 bubble,
	output logic                                 stallAll,
	output cpuPkg::fwdSelT                       fwdA,
	output cpuPkg::fwdSelT                       fwdB,
	output logic                                 halt
);
	import cpuPkg::*;

	logic [RegAddrWidth-1:0] exRs, exRt;
	logic loadUse, haltQ;

	assign loadUse = exLoad && exWrEn && exRd != '0 && (exRd == rsAddr || exRd == rtAddr);

	assign stallAll = memBusy;
	assign stallFront = loadUse & ~stallAll;
	assign bubble = loadUse & ~stallAll;

	// Source addresses of the instruction now in execute
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exRs <= '0;
			exRt <= '0;
		end else if (!stallAll) begin
			exRs <= bubble ? '0 : rsAddr;
			exRt <= bubble ? '0 : rtAddr;
		end
	end

	// Memory stage is the younger producer
	assign fwdA = (memWrEn && memRd != '0 && memRd == exRs) ? FwdMem :
		(wbWrEn && wbRd != '0 && wbRd == exRs) ? FwdWb : FwdReg;
	assign fwdB = (memWrEn && memRd != '0 && memRd == exRt) ? FwdMem :
		(wbWrEn && wbRd != '0 && wbRd == exRt) ? FwdWb : FwdReg;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			haltQ <= 1'b0;
		end else if (wbHalt) begin
			haltQ <= 1'b1;
		end
	end

	assign halt = haltQ | wbHalt;

endmodule

`default_nettype wire

/* src/regFile.sv */
// Register file with two read ports, one write port and write-through bypass
`default_nettype none

module regFile (
	input  wire logic                            clk,
	input  wire logic                            rstN,
	input  wire logic [cpuPkg::RegAddrWidth-1:0] rsAddr,
	input  wire logic [cpuPkg::RegAddrWidth-1:0] rtAddr,
	input  wire logic                            wrEn,
	input  wire logic [cpuPkg::RegAddrWidth-1:0] wrAddr,
	input  wire logic [cpuPkg::XLEN-1:0]         wrData,
	output logic      [cpuPkg::XLEN-1:0]         rsData,
	output logic      [cpuPkg::XLEN-1:0]         rtData
);
	import cpuPkg::*;

	logic [XLEN-1:0] regs [2**RegAddrWidth];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 2**RegAddrWidth; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Same-cycle write wins over the stored value
	assign rsData = (rsAddr == '0) ? '0 :
		(wrEn && wrAddr == rsAddr) ? wrData : regs[rsAddr];
	assign rtData = (rtAddr == '0) ? '0 :
		(wrEn && wrAddr == rtAddr) ? wrData : regs[rtAddr];

endmodule

`default_nettype wire

/* tb.f */
+incdir+tests
src/cpuPkg.sv
src/regFile.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/pipelineControl.sv
src/cpuCore.sv
tests/cpuCoreTb.sv

/* tests/cpuRefModel.svh */
// Test program table, data fill pattern and architectural reference model
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

localparam int RomDepth = 64;

logic [31:0] rom [RomDepth];
int progLen;

// Expected register writes and stores, in program order
logic [4:0] expRegAddr [$];
logic [31:0] expRegData [$];
logic [15:0] expMemAddr [$];
logic [31:0] expMemData [$];

function automatic logic [31:0] encodeReg(opcodeT op, logic [4:0] rd, logic [4:0] rs,
		logic [4:0] rt);
	return {op, rd, rs, rt, 11'd0};
endfunction

function automatic logic [31:0] encodeImm(opcodeT op, logic [4:0] rd, logic [4:0] rs,
		logic [15:0] imm);
	return {op, rd, rs, imm};
endfunction

// Every bit of the word address changes the pattern
function automatic logic [31:0] fillWord(int addr);
	return (addr * 32'h9E37_79B9) ^ 32'h5A5A_0000;
endfunction

function automatic void appendInstr(logic [31:0] word);
	rom[progLen] = word;
	progLen++;
endfunction

function automatic void loadProgram();
	int i;
	for (i = 0; i < RomDepth; i++) rom[i] = NopInstr;
	progLen = 0;
	// ALU ops, negative immediates, forwarding at distances one to three
	appendInstr(encodeImm(OpAddi, 1, 0, 5));
	appendInstr(encodeImm(OpAddi, 2, 0, -16'sd3));
	appendInstr(encodeReg(OpAdd, 3, 1, 2));
	appendInstr(encodeReg(OpSub, 4, 3, 1));
	appendInstr(encodeReg(OpAnd, 5, 4, 3));
	appendInstr(encodeReg(OpOr, 6, 5, 1));
	appendInstr(encodeReg(OpXor, 7, 6, 2));
	appendInstr(encodeReg(OpSlt, 8, 2, 1));
	appendInstr(encodeReg(OpSlt, 9, 1, 2));
	appendInstr(encodeImm(OpAddi, 0, 1, 7));
	appendInstr(encodeReg(OpAdd, 10, 0, 1));
	appendInstr(encodeImm(OpAddi, 11, 2, -16'sd100));
	// Store then load of one address, load-use on ALU and store data
	appendInstr(encodeImm(OpSw, 11, 1, 16));
	appendInstr(encodeImm(OpLw, 12, 0, 21));
	appendInstr(encodeReg(OpAdd, 13, 12, 1));
	appendInstr(encodeImm(OpLw, 14, 0, 40));
	appendInstr(encodeImm(OpSw, 14, 0, 50));
	appendInstr(encodeImm(OpLw, 15, 0, 50));
	appendInstr(encodeReg(OpXor, 16, 15, 14));
	appendInstr(encodeImm(OpAddi, 17, 16, 1));
	appendInstr(NopInstr);
	appendInstr(encodeReg(OpSub, 18, 17, 13));
	appendInstr(encodeReg(OpAdd, 19, 18, 18));
	appendInstr(encodeReg(OpSlt, 20, 19, 0));
	// Writeback operand held across a memory stall
	appendInstr(encodeImm(OpAddi, 24, 19, -16'sd7));
	appendInstr(encodeImm(OpLw, 25, 0, 33));
	appendInstr(encodeReg(OpSub, 26, 24, 13));
	appendInstr(encodeImm(OpHalt, 0, 0, 0));
	// Never retires
	appendInstr(encodeImm(OpAddi, 21, 0, 99));
endfunction

function automatic void refRun();
	logic [31:0] regs [32];
	logic [31:0] mem [256];
	logic [31:0] word, a, b, imm, addr, res;
	logic [4:0] rd;
	logic writes, done;
	int i;
	for (i = 0; i < 32; i++) regs[i] = '0;
	for (i = 0; i < 256; i++) mem[i] = fillWord(i);
	done = 1'b0;
	for (i = 0; i < progLen && !done; i++) begin
		word = rom[i];
		rd = word[25:21];
		a = regs[word[20:16]];
		b = regs[word[15:11]];
		imm = {{16{word[15]}}, word[15:0]};
		addr = a + imm;
		writes = 1'b1;
		res = '0;
		case (opcodeT'(word[31:26]))
			OpAdd: res = a + b;
			OpSub: res = a - b;
			OpAnd: res = a & b;
			OpOr: res = a | b;
			OpXor: res = a ^ b;
			OpSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			OpAddi: res = addr;
			OpLw: res = mem[addr[7:0]];
			OpSw: begin
				writes = 1'b0;
				mem[addr[7:0]] = regs[rd];
				expMemAddr.push_back(addr[15:0]);
				expMemData.push_back(regs[rd]);
			end
			OpHalt: begin
				writes = 1'b0;
				done = 1'b1;
			end
			default: writes = 1'b0;
		endcase
		if (writes && rd != '0) begin
			regs[rd] = res;
			expRegAddr.push_back(rd);
			expRegData.push_back(res);
		end
	end
endfunction

`endif

/* tests/cpuCoreTb.sv */
// Testbench for the pipelined core with instruction ROM, data-memory responder and trace checks
`default_nettype none

module cpuCoreTb;
	timeunit 1ns;
	timeprecision 100ps;
	import cpuPkg::*;

	localparam int ResetCycles = 10;
	localparam int DataAddrWidth = 16;
	localparam logic [31:0] IdleRdata = 32'hDEAD_BEEF;
	localparam int PhIdle = 0;
	localparam int PhAck = 1;
	localparam int PhHold = 2;
	localparam int PhRelease = 3;

	logic clk, rstN;
	logic [XLEN-1:0] instr, memRdata, instrAddr, memWdata, wbData;
	logic memAck, memReq, memWe, wbEn, halt;
	logic [DataAddrWidth-1:0] memAddr;
	logic [RegAddrWidth-1:0] wbAddr;

	`include "cpuRefModel.svh"

	logic [XLEN-1:0] dataMem [256];
	integer seed;
	int cycleCount, checkCount;
	int resetErrs, traceErrs, memErrs, haltErrs;
	int phase, waitCycles;
	logic reqPrev;
	logic [DataAddrWidth+XLEN:0] reqFields;

	cpuCore #(.ResetPc('0), .DataAddrWidth(DataAddrWidth)) UUT (
		.clk(clk), .rstN(rstN), .instr(instr), .memAck(memAck), .memRdata(memRdata),
		.instrAddr(instrAddr), .memReq(memReq), .memWe(memWe), .memAddr(memAddr),
		.memWdata(memWdata), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData), .halt(halt)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) cycleCount <= cycleCount + 1;

	// Zero-wait instruction ROM
	always @(posedge clk) begin
		#1;
		instr = (instrAddr < RomDepth) ? rom[instrAddr] : NopInstr;
	end

	task automatic expectLow(string name, logic value, string when);
		checkCount++;
		if (value !== 1'b0) begin
			$display("** Error: %s %s expected 0 got %h", name, when, value);
			resetErrs++;
		end
	endtask

	task automatic checkIdleOutputs(string when);
		expectLow("memReq", memReq, when);
		expectLow("wbEn", wbEn, when);
		expectLow("halt", halt, when);
	endtask

	task automatic serveAccess();
		logic [DataAddrWidth-1:0] ea;
		logic [XLEN-1:0] ed;
		if (memWe) begin
			if (expMemAddr.size() == 0) begin
				$display("Store to address %h was not expected by the reference model", memAddr);
				memErrs++;
			end else begin
				ea = expMemAddr.pop_front();
				ed = expMemData.pop_front();
				checkCount += 2;
				if (memAddr !== ea) begin
					$display("** Error: memAddr expected %h got %h", ea, memAddr);
					memErrs++;
				end
				if (memWdata !== ed) begin
					$display("** Error: memWdata expected %h got %h", ed, memWdata);
					memErrs++;
				end
			end
			dataMem[memAddr[7:0]] = memWdata;
		end else begin
			memRdata = dataMem[memAddr[7:0]];
		end
	endtask

	// Four-phase slave with random ack and release delays
	always @(posedge clk) begin
		#1;
		if (!rstN) begin
			memAck = 1'b0;
			phase = PhIdle;
			reqPrev = 1'b0;
		end else begin
			if (memReq && !reqPrev && memAck) begin
				$display("Handshake error: memReq rose while memAck was still high");
				memErrs++;
			end
			if (memReq && reqPrev && {memWe, memAddr, memWdata} !== reqFields) begin
				$display("Handshake error: request fields changed while memReq was high");
				memErrs++;
			end
			if (memReq && !reqPrev) reqFields = {memWe, memAddr, memWdata};
			if (phase == PhIdle && memReq) begin
				waitCycles = $unsigned($random(seed)) % 6;
				phase = PhAck;
			end
			if (phase == PhAck) begin
				if (waitCycles == 0) begin
					serveAccess();
					memAck = 1'b1;
					phase = PhHold;
				end else begin
					waitCycles--;
				end
			end else if (phase == PhHold && !memReq) begin
				waitCycles = $unsigned($random(seed)) % 6;
				phase = PhRelease;
			end
			if (phase == PhRelease) begin
				if (waitCycles == 0) begin
					memAck = 1'b0;
					memRdata = IdleRdata;
					phase = PhIdle;
				end else begin
					waitCycles--;
				end
			end
			reqPrev = memReq;
		end
	end

	task automatic checkTrace(logic [4:0] expAddr, logic [31:0] expData);
		checkCount += 2;
		if (wbAddr !== expAddr) begin
			$display("** Error: wbAddr expected %h got %h", expAddr, wbAddr);
			traceErrs++;
		end
		if (wbData !== expData) begin
			$display("** Error: wbData expected %h got %h", expData, wbData);
			traceErrs++;
		end
	endtask

	// Trace comparison against the reference queue
	always @(negedge clk) begin
		if (rstN && wbEn) begin
			if (halt) begin
				$display("Trace write to r%0d appeared after halt", wbAddr);
				haltErrs++;
			end
			if (wbAddr == '0) begin
				$display("Trace write to register zero appeared");
				traceErrs++;
			end
			if (expRegAddr.size() == 0) begin
				$display("Trace write to r%0d is not expected by the reference model", wbAddr);
				traceErrs++;
			end else begin
				checkTrace(expRegAddr.pop_front(), expRegData.pop_front());
			end
		end
	end

	task automatic reportTest(string name, int errs);
		$display("Test %s: %s, %0d errors", name, (errs == 0) ? "pass" : "fail", errs);
	endtask

	initial begin
		int i;
		int errTotal;
		rstN = 1'b0;
		instr = NopInstr;
		memAck = 1'b0;
		memRdata = IdleRdata;
		seed = 89;
		reqPrev = 1'b0;
		phase = PhIdle;
		waitCycles = 0;
		cycleCount = 0;
		checkCount = 0;
		resetErrs = 0;
		traceErrs = 0;
		memErrs = 0;
		haltErrs = 0;
		for (i = 0; i < 256; i++) dataMem[i] = fillWord(i);
		loadProgram();
		refRun();
		for (i = 0; i < ResetCycles; i++) begin
			@(posedge clk);
			#1;
			checkIdleOutputs("during reset");
		end
		rstN = 1'b1;
		@(posedge clk);
		#1;
		checkIdleOutputs("after reset");
		reportTest("reset", resetErrs);
		while (!halt && cycleCount < progLen * 20 + ResetCycles) begin
			@(posedge clk);
			#2;
		end
		if (!halt) begin
			$display("Timeout: halt did not rise within %0d cycles", cycleCount);
			$display("TESTBENCH FAILED");
			$finish;
		end else begin
			checkCount++;
			if (expRegAddr.size() != 0) begin
				$display("Halt rose with %0d register writes still expected", expRegAddr.size());
				haltErrs++;
			end
			// Quiet period to catch late trace writes
			repeat (10) @(posedge clk);
			#2;
			checkCount += 2;
			if (!halt) begin
				$display("Halt dropped after it had risen");
				haltErrs++;
			end
			if (expMemAddr.size() != 0) begin
				$display("%0d expected stores never reached the data memory", expMemAddr.size());
				haltErrs++;
			end
			reportTest("trace", traceErrs);
			reportTest("memory", memErrs);
			reportTest("halt", haltErrs);
			errTotal = resetErrs + traceErrs + memErrs + haltErrs;
			$display("Checks: %0d run, %0d errors", checkCount, errTotal);
			if (errTotal == 0) begin
				$display("TESTBENCH PASSED");
			end else begin
				$display("TESTBENCH FAILED");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire
